// File: list.f
daq_pkg.sv
time_base.sv
latch_stamper.sv
daq_arbiter.sv
daq_top.sv
tb_clock.sv
daq_props.sv
tb_daq.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_daq
FILELIST = list.f
PASS_MSG = Simulation passed

.PHONY: simulate clean

# the run passes only if the pass message shows up in the output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: tb_daq.sv
`timescale 1ns/1ps

module tb_daq;

	localparam int NCHAN = 4;
	localparam int LED_SHIFT = 4;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;

	// cycle budget of each test, the watchdog adds them up
	localparam int CYC_RESET = 20;
	localparam int CYC_LOAD = 20;
	localparam int CYC_LED = 60;
	localparam int CYC_SINGLE = NCHAN * 50;
	localparam int CYC_CONTENTION = 80;
	localparam int CYC_DROP = 120;
	localparam int CYC_MARGIN = 200;
	localparam int RUN_CYCLES = RESET_CYCLES + CYC_RESET + CYC_LOAD + CYC_LED + CYC_SINGLE +
		CYC_CONTENTION + CYC_DROP + CYC_MARGIN;

	localparam int REC_WAIT = 30;	// latch edge to first record, more is added per record
	localparam int IDLE_WAIT = 20;

	logic clk;
	logic rst;
	daq_pkg::systime_t systime_set;
	logic systime_set_en;
	logic [NCHAN-1:0] latch;
	daq_pkg::systime_t systime;
	logic [7:0] leds;
	daq_pkg::daq_word_t daq_data;
	logic daq_valid;
	logic daq_end;

	logic [63:0] rec_q[$];	// one entry per record, first word in the upper half
	logic have_first;
	daq_pkg::daq_word_t first_word;
	int seed = 32'h26ff;

	tb_clock #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(RESET_CYCLES)
	) u_clock (
		.clk(clk),
		.rst(rst)
	);

	daq_top #(
		.NCHAN(NCHAN),
		.LED_SHIFT(LED_SHIFT)
	) uut (
		.clk(clk),
		.rst(rst),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.latch(latch),
		.systime(systime),
		.leds(leds),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end)
	);

	bind daq_arbiter daq_props #(
		.NCHAN(NCHAN)
	) u_props (
		.clk(clk),
		.rst(rst),
		.grant(grant),
		.daq_valid(daq_valid),
		.daq_end(daq_end)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [7:0] rotate_left(input logic [7:0] v);
		return (v << 1) | (v >> 7);
	endfunction

	// the stamp is the time two cycles after the cycle in which the pin went high
	function automatic daq_pkg::stamp_t expected_stamp(input daq_pkg::systime_t t0);
		daq_pkg::systime_t t;
		t = t0 + 64'd2;
		return t[daq_pkg::STAMP_W-1:0];
	endfunction

	// gathers outlet words into records and checks that the two words are adjacent
	always @(negedge clk) begin
		if (rst) begin
			have_first = 1'b0;
		end else if (daq_valid && !daq_end) begin
			if (have_first) begin
				report_error("outlet: a new record started before the previous one ended");
			end else begin
				first_word = daq_data;
				have_first = 1'b1;
			end
		end else if (daq_valid && daq_end) begin
			if (!have_first) begin
				report_error("outlet: an end word arrived without a first word");
			end else begin
				rec_q.push_back({first_word, daq_data});
				have_first = 1'b0;
			end
		end else if (daq_end) begin
			report_error("outlet: daq_end is high while daq_valid is low");
		end else if (have_first) begin
			report_error("outlet: gap between the two words of a record");
		end
	end

	task automatic wait_records(input string name, input int count);
		int cycles;
		int limit;
		cycles = 0;
		limit = REC_WAIT + 8 * count;
		while (rec_q.size() < count) begin
			if (cycles >= limit) begin
				report_error($sformatf("%s: only %0d of %0d records arrived on the outlet",
					name, rec_q.size(), count));
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	// one-cycle pulse on the selected pins, t0 is the time while they are high
	task automatic fire_latch(input logic [NCHAN-1:0] mask, output daq_pkg::systime_t t0);
		@(posedge clk);
		latch <= mask;
		@(negedge clk);
		t0 = systime;
		@(posedge clk);
		latch <= '0;
	endtask

	task automatic check_record(input string name, input int idx, input int chan,
		input daq_pkg::systime_t t0);
		logic [63:0] rec;
		rec = rec_q[idx];
		check_value({name, " tag"}, daq_pkg::DAQT_LATCH_BASE + chan, rec[63 -: daq_pkg::TAG_W]);
		check_value({name, " stamp"}, expected_stamp(t0), rec[daq_pkg::STAMP_W-1:0]);
	endtask

	task automatic test_reset_state;
		daq_pkg::systime_t prev;
		check_value("reset leds", daq_pkg::LED_RESET, leds);
		check_value("reset daq_valid", 1'b0, daq_valid);
		check_value("reset daq_end", 1'b0, daq_end);
		check_value("reset systime", 64'd0, systime);
		prev = systime;
		repeat (8) begin
			@(negedge clk);
			check_value("reset count", prev + 64'd1, systime);
			prev = systime;
		end
	endtask

	task automatic test_time_load;
		daq_pkg::systime_t value;
		value = 64'h0123_4567_ffff_fffe;	// the count carries out of the low word
		@(posedge clk);
		systime_set <= value;
		systime_set_en <= 1'b1;
		@(posedge clk);
		systime_set_en <= 1'b0;
		@(negedge clk);
		check_value("time load", value, systime);
		for (int i = 1; i <= 3; i++) begin
			@(negedge clk);
			check_value("time load count", value + 64'(i), systime);
		end
	endtask

	task automatic test_led_chaser;
		daq_pkg::systime_t prev_t;
		logic [7:0] prev_l;
		logic [7:0] expected;
		int steps;
		steps = 0;
		@(negedge clk);
		prev_t = systime;
		prev_l = leds;
		repeat (48) begin
			@(negedge clk);
			if (prev_t[LED_SHIFT-1:0] == '0) begin
				expected = rotate_left(prev_l);
				steps++;
			end else begin
				expected = prev_l;
			end
			check_value("led chaser", expected, leds);
			prev_t = systime;
			prev_l = leds;
		end
		check_value("led chaser steps", 64'd3, 64'(steps));	// 48 edges hold three wraps
	endtask

	task automatic test_single_latch;
		daq_pkg::systime_t t0;
		int gap;
		for (int k = 0; k < NCHAN; k++) begin
			gap = $random(seed) & 7;
			repeat (gap) @(posedge clk);
			rec_q.delete();
			fire_latch(NCHAN'(1) << k, t0);
			wait_records($sformatf("single latch %0d", k), 1);
			repeat (IDLE_WAIT) @(posedge clk);
			check_value($sformatf("single latch %0d count", k), 64'd1, 64'(rec_q.size()));
			check_record($sformatf("single latch %0d", k), 0, k, t0);
		end
	endtask

	task automatic test_contention;
		daq_pkg::systime_t t0;
		logic [63:0] rec;
		logic [NCHAN-1:0] seen;
		int chan;
		seen = '0;
		rec_q.delete();
		fire_latch('1, t0);
		wait_records("contention", NCHAN);
		repeat (IDLE_WAIT) @(posedge clk);
		check_value("contention count", 64'(NCHAN), 64'(rec_q.size()));
		for (int i = 0; i < NCHAN; i++) begin
			rec = rec_q[i];
			chan = int'(rec[63 -: daq_pkg::TAG_W]) - int'(daq_pkg::DAQT_LATCH_BASE);
			if (chan >= 0 && chan < NCHAN) begin
				seen[chan] = 1'b1;
			end
			check_value("contention stamp", expected_stamp(t0), rec[daq_pkg::STAMP_W-1:0]);
		end
		check_value("contention tags", {NCHAN{1'b1}}, seen);	// all distinct
	endtask

	task automatic test_dropped_edge(input int k);
		daq_pkg::systime_t t0;
		daq_pkg::systime_t t1;
		int gap;
		rec_q.delete();
		fire_latch(NCHAN'(1) << k, t0);
		// second pulse reaches the edge detector while req is still pending
		@(posedge clk);
		latch[k] <= 1'b1;
		@(posedge clk);
		latch[k] <= 1'b0;
		wait_records("dropped edge", 1);
		repeat (IDLE_WAIT) @(posedge clk);
		check_value("dropped edge count", 64'd1, 64'(rec_q.size()));
		check_record("dropped edge", 0, k, t0);
		gap = $random(seed) & 7;
		repeat (gap) @(posedge clk);
		fire_latch(NCHAN'(1) << k, t1);
		wait_records("dropped edge later pulse", 2);
		repeat (IDLE_WAIT) @(posedge clk);
		check_value("dropped edge later count", 64'd2, 64'(rec_q.size()));
		check_record("dropped edge later pulse", 1, k, t1);
	endtask

	initial begin
		latch = '0;
		systime_set = '0;
		systime_set_en = 1'b0;
		@(negedge clk);
		while (rst) @(negedge clk);
		test_reset_state();
		test_time_load();
		test_led_chaser();
		test_single_latch();
		test_contention();
		test_dropped_edge(2);
		$display("Simulation passed");
		$finish;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog: the tests did not finish within %0d clock cycles", RUN_CYCLES);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

// File: daq_props.sv
`timescale 1ns/1ps

module daq_props #(
	parameter int NCHAN = 4
) (
	input logic clk,
	input logic rst,
	input logic [NCHAN-1:0] grant,
	input logic daq_valid,
	input logic daq_end
);

	// only one stamper may own the outlet at a time
	grant_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(grant)
	) else $error("grant is high on more than one channel");

	end_has_valid: assert property (
		@(posedge clk) disable iff (rst) daq_end |-> daq_valid
	) else $error("daq_end is high without daq_valid");

	// a record is always two words, back to back
	record_two_words: assert property (
		@(posedge clk) disable iff (rst)
		(daq_valid && !daq_end) |=> (daq_valid && daq_end)
	) else $error("the first word of a record is not followed by its end word");

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset falls right after a rising edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: daq_top.sv
`timescale 1ns/1ps

module daq_top #(
	parameter int NCHAN = 4,
	parameter int LED_SHIFT = 22
) (
	input logic clk,
	input logic rst,

	// time load from the host
	input daq_pkg::systime_t systime_set,
	input logic systime_set_en,

	// one external sync pin per stamper channel
	input logic [NCHAN-1:0] latch,

	output daq_pkg::systime_t systime,
	output logic [7:0] leds,

	output daq_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end
);

	logic [NCHAN-1:0] chan_req;
	logic [NCHAN-1:0] chan_grant;
	daq_pkg::daq_word_t [NCHAN-1:0] chan_data;
	logic [NCHAN-1:0] chan_valid;
	logic [NCHAN-1:0] chan_end;

	time_base #(
		.LED_SHIFT(LED_SHIFT)
	) u_time_base (
		.clk(clk),
		.rst(rst),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime),
		.leds(leds)
	);

	// every channel stamps the same time base, the tag tells them apart
	for (genvar i = 0; i < NCHAN; i++) begin : g_stamper
		latch_stamper #(
			.CHAN_ID(i)
		) u_latch_stamper (
			.clk(clk),
			.rst(rst),
			.latch(latch[i]),
			.systime(systime),
			.req(chan_req[i]),
			.grant(chan_grant[i]),
			.data(chan_data[i]),
			.valid(chan_valid[i]),
			.rec_end(chan_end[i])
		);
	end

	daq_arbiter #(
		.NCHAN(NCHAN)
	) u_daq_arbiter (
		.clk(clk),
		.rst(rst),
		.req(chan_req),
		.grant(chan_grant),
		.chan_data(chan_data),
		.chan_valid(chan_valid),
		.chan_end(chan_end),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end)
	);

endmodule

// File: daq_arbiter.sv
`timescale 1ns/1ps

module daq_arbiter #(
	parameter int NCHAN = 4
) (
	input logic clk,
	input logic rst,

	// one req/grant pair and one word lane per channel
	input logic [NCHAN-1:0] req,
	output logic [NCHAN-1:0] grant,
	input daq_pkg::daq_word_t [NCHAN-1:0] chan_data,
	input logic [NCHAN-1:0] chan_valid,
	input logic [NCHAN-1:0] chan_end,

	// merged outlet, no back-pressure
	output daq_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end
);

	localparam int PTR_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

	logic [PTR_W-1:0] last;	// last granted channel, also selects the word lane
	logic busy;	// set from grant until the end word is on the outlet

	logic found;
	logic [PTR_W-1:0] pick;

	// search starts one past the last winner, so every requester gets its turn
	always_comb begin : rr_pick
		int idx;

		found = 1'b0;
		pick = last;
		for (int i = 1; i <= NCHAN; i++) begin
			idx = (int'(last) + i) % NCHAN;
			if (!found && req[idx]) begin
				found = 1'b1;
				pick = PTR_W'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			busy <= 1'b0;
			last <= PTR_W'(NCHAN - 1);	// channel 0 comes first after reset
		end else begin
			grant <= '0;	// grant is a single-cycle pulse
			if (!busy && found) begin
				grant[pick] <= 1'b1;
				last <= pick;
				busy <= 1'b1;
			end else if (busy && chan_valid[last] && chan_end[last]) begin
				busy <= 1'b0;	// a new grant can follow one cycle after daq_end
			end
		end
	end

	// words are taken from the granted lane only, one cycle behind the channel
	always_ff @(posedge clk) begin
		if (rst) begin
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
		end else begin
			daq_valid <= busy & chan_valid[last];
			daq_end <= busy & chan_valid[last] & chan_end[last];
		end
	end

	always_ff @(posedge clk) begin
		if (busy && chan_valid[last]) begin
			daq_data <= chan_data[last];
		end
	end

endmodule

// File: latch_stamper.sv
`timescale 1ns/1ps

module latch_stamper #(
	parameter int CHAN_ID = 0
) (
	input logic clk,
	input logic rst,

	input logic latch,	// asynchronous sync pin
	input daq_pkg::systime_t systime,

	// record handshake towards the arbiter
	output logic req,
	input logic grant,
	output daq_pkg::daq_word_t data,
	output logic valid,
	output logic rec_end
);

	localparam daq_pkg::daq_tag_t TAG =
		daq_pkg::daq_tag_t'(daq_pkg::DAQT_LATCH_BASE + CHAN_ID);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_GRANT,
		ST_SEND_LOWER
	} state_t;

	state_t state;

	logic [daq_pkg::SYNC_STAGES-1:0] sync_q;
	logic latch_prev;
	logic latch_s;
	logic rise;

	daq_pkg::stamp_t stamp;

	// the oldest synchronizer stage is the only one that may be used
	assign latch_s = sync_q[daq_pkg::SYNC_STAGES-1];
	assign rise = latch_s & ~latch_prev;

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '0;
			latch_prev <= 1'b0;
		end else begin
			sync_q <= {sync_q[daq_pkg::SYNC_STAGES-2:0], latch};
			latch_prev <= latch_s;	// tracks the pin even while busy, so busy edges are lost
		end
	end

	// the record carries the low 56 bits of the time at the detected edge
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && rise) begin
			stamp <= systime[daq_pkg::STAMP_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			req <= 1'b0;
			valid <= 1'b0;
			rec_end <= 1'b0;
		end else begin
			valid <= 1'b0;
			rec_end <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rise) begin
						req <= 1'b1;
						state <= ST_WAIT_GRANT;
					end
				end
				ST_WAIT_GRANT: begin
					if (grant) begin	// req may be held here for any number of cycles
						req <= 1'b0;
						valid <= 1'b1;
						state <= ST_SEND_LOWER;
					end
				end
				ST_SEND_LOWER: begin
					valid <= 1'b1;
					rec_end <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// tag word on the grant, low stamp word right after it
	always_ff @(posedge clk) begin
		if (state == ST_WAIT_GRANT && grant) begin
			data <= {TAG, stamp[daq_pkg::STAMP_W-1 -: daq_pkg::STAMP_HI_W]};
		end else if (state == ST_SEND_LOWER) begin
			data <= stamp[daq_pkg::WORD_W-1:0];
		end
	end

endmodule

// File: time_base.sv
`timescale 1ns/1ps

module time_base #(
	parameter int LED_SHIFT = 22
) (
	input logic clk,
	input logic rst,

	input daq_pkg::systime_t systime_set,
	input logic systime_set_en,

	output daq_pkg::systime_t systime,
	output logic [7:0] leds
);

	logic led_step;

	// the chaser moves once per 2**LED_SHIFT cycles of the counter
	assign led_step = (systime[LED_SHIFT-1:0] == '0);

	// the host may load a new time at any cycle, the load wins over the increment
	always_ff @(posedge clk) begin
		if (rst) begin
			systime <= '0;
		end else if (systime_set_en) begin
			systime <= systime_set;
		end else begin
			systime <= systime + 1'b1;
		end
	end

	// rotate left, the top led wraps around to the bottom
	always_ff @(posedge clk) begin
		if (rst) begin
			leds <= daq_pkg::LED_RESET;
		end else if (led_step) begin
			leds <= {leds[6:0], leds[7]};
		end
	end

endmodule

// File: daq_pkg.sv
package daq_pkg;

	// field widths of the time base and the outlet words
	localparam int SYSTIME_W = 64;
	localparam int STAMP_W = 56;
	localparam int WORD_W = 32;
	localparam int TAG_W = 8;

	typedef logic [SYSTIME_W-1:0] systime_t;	// free running system time
	typedef logic [STAMP_W-1:0] stamp_t;	// low part of the system time kept in a record
	typedef logic [WORD_W-1:0] daq_word_t;	// one word on the daq outlet
	typedef logic [TAG_W-1:0] daq_tag_t;	// record type, top byte of the first word

	// latch channel k reports with tag DAQT_LATCH_BASE + k
	localparam daq_tag_t DAQT_LATCH_BASE = 8'd40;

	// flops between the sync pin and the edge detector
	localparam int SYNC_STAGES = 2;

	// a single lit led, which the chaser then walks around
	localparam logic [7:0] LED_RESET = 8'b00000001;

	// the first word carries the tag and the upper stamp bits,
	// so tag and upper stamp must fill exactly one word
	localparam int STAMP_HI_W = STAMP_W - WORD_W;

endpackage
